// ==== rtl/memoryPkg.sv ====
/*
  Widths, enums and structs shared by the array heap.
  Widths are fixed here because the request and response structs depend on them.
*/
package memoryPkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int addressBits = 2;                      // Four arrays
  localparam int indexBits   = 3;                      // Eight elements per array
  localparam int dataBits    = 16;                     // Element width
  localparam int arrayCount  = 1 << addressBits;
  localparam int arrayLength = 1 << indexBits;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------
  typedef enum logic [3:0] {
    opAlloc    = 4'd0,                                 // Allocate, returns array number
    opFree     = 4'd1,                                 // Release a live array
    opWrite    = 4'd2,                                 // Store element, may grow size
    opRead     = 4'd3,
    opSize     = 4'd4,
    opPush     = 4'd5,                                 // Append at size
    opPop      = 4'd6,                                 // Remove and return top
    opAdd      = 4'd7,                                 // Read-modify-write group
    opSubtract = 4'd8,
    opOr       = 4'd9,
    opXor      = 4'd10,
    opAnd      = 4'd11
  } opcodeT;

  typedef enum logic [2:0] {
    errorNone         = 3'd0,
    errorNotAllocated = 3'd1,                          // Array never handed out
    errorFreed        = 3'd2,                          // Array released earlier
    errorOutOfBounds  = 3'd3,
    errorFull         = 3'd4,                          // Push at size eight
    errorEmpty        = 3'd5,                          // Pop at size zero
    errorOutOfMemory  = 3'd6
  } errorT;

  typedef enum logic [1:0] {
    stateUnused = 2'd0,
    stateLive   = 2'd1,
    stateFreed  = 2'd2
  } arrayStateT;

  // ------------------------------------------------------------------------
  // Request and response
  // ------------------------------------------------------------------------
  typedef struct packed {
    opcodeT                 opcode;
    logic [addressBits-1:0] array;
    logic [indexBits-1:0]   index;
    logic [dataBits-1:0]    data;
  } requestT;                                          // 25 bits

  typedef struct packed {
    logic [dataBits-1:0] data;                         // Zero on any error
    errorT               error;
  } responseT;                                         // 19 bits

endpackage

// ==== rtl/requestIntake.sv ====
/*
  One register stage between the client and the execute stage.
  Ready is withheld early enough that the response queue never overflows,
  counting the staged request and the one being pushed.
*/
`timescale 1ns/1ps

module requestIntake #(
  parameter int queueDepth = 4
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             reqValid,
  output logic                             reqReady,
  input  memoryPkg::requestT               req,
  input  logic [$clog2(queueDepth+1)-1:0]  queueFill,
  output logic                             stageValid,
  output memoryPkg::requestT               stageRequest
);

  localparam int countBits = $clog2(queueDepth + 1);

  logic                 accept;                        // Handshake this cycle
  logic                 pushPending;                   // Executed last cycle, queue write due
  logic [countBits+1:0] inFlight;                      // Queue fill plus both pipe slots

  assign accept = reqValid && reqReady;

  // Occupancy once everything already accepted has landed in the queue
  assign inFlight = {2'b00, queueFill}
                  + (countBits + 2)'(stageValid)
                  + (countBits + 2)'(pushPending);
  assign reqReady = inFlight < (countBits + 2)'(queueDepth);

  // ------------------------------------------------------------------------
  // Stage control
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      stageValid  <= 1'b0;
      pushPending <= 1'b0;
    end else begin
      stageValid  <= accept;                           // Valid for exactly one cycle
      pushPending <= stageValid;                       // Execute never stalls
    end
  end

  // Payload register
  always_ff @(posedge clock) begin
    if (accept) begin
      stageRequest <= req;
    end
  end

endmodule

// ==== rtl/arrayAllocator.sv ====
/*
  Tracks which arrays are live and hands out array numbers.
  Freed arrays are reused last-in first-out before any new number is taken.
  The caller only raises freeRequest for a live array, so the stack cannot overflow.
*/
`timescale 1ns/1ps

module arrayAllocator (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [memoryPkg::addressBits-1:0]      lookupArray,
  output memoryPkg::arrayStateT                  arrayState,
  input  logic                                   allocRequest,
  input  logic                                   freeRequest,
  output logic [memoryPkg::addressBits-1:0]      allocResult,
  output logic                                   allocFailed
);

  localparam int addressBits = memoryPkg::addressBits;
  localparam int arrayCount  = memoryPkg::arrayCount;

  logic [arrayCount-1:0]  liveFlags;                   // One per array
  logic [addressBits-1:0] freeStack [arrayCount];      // Freed array numbers
  logic [addressBits:0]   stackTop;                    // Entries on the free stack
  logic [addressBits:0]   highWater;                   // Arrays ever handed out
  logic                   stackEmpty;
  logic [addressBits-1:0] stackIndex;

  assign stackEmpty = stackTop == '0;
  assign stackIndex = stackTop[addressBits-1:0];

  // ------------------------------------------------------------------------
  // Combinational lookup
  // ------------------------------------------------------------------------
  always_comb begin
    if ({1'b0, lookupArray} >= highWater) begin
      arrayState = memoryPkg::stateUnused;             // Beyond anything handed out
    end else if (liveFlags[lookupArray]) begin
      arrayState = memoryPkg::stateLive;
    end else begin
      arrayState = memoryPkg::stateFreed;
    end
  end

  // Most recent free first, else next fresh number
  assign allocResult = stackEmpty ? highWater[addressBits-1:0]
                                  : freeStack[stackIndex - 1'b1];
  assign allocFailed = stackEmpty && (highWater == (addressBits + 1)'(arrayCount));

  // ------------------------------------------------------------------------
  // State update on the execute edge
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      liveFlags <= '0;
      stackTop  <= '0;
      highWater <= '0;
    end else if (allocRequest) begin
      liveFlags[allocResult] <= 1'b1;
      if (stackEmpty) begin
        highWater <= highWater + 1'b1;                 // Fresh array
      end else begin
        stackTop  <= stackTop - 1'b1;                  // Reuse freed array
      end
    end else if (freeRequest) begin
      liveFlags[lookupArray] <= 1'b0;
      stackTop               <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (freeRequest) begin
      freeStack[stackIndex] <= lookupArray;            // Push on top
    end
  end

endmodule

// ==== rtl/arrayStore.sv ====
/*
  Execute stage. Checks each staged request, updates element memory and sizes,
  and registers exactly one response per request into the output queue.
  Errors return data zero and change no state. Arithmetic wraps at dataBits.
*/
`timescale 1ns/1ps

module arrayStore (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   stageValid,
  input  memoryPkg::requestT                     stageRequest,
  input  memoryPkg::arrayStateT                  arrayState,
  input  logic [memoryPkg::addressBits-1:0]      allocResult,
  input  logic                                   allocFailed,
  output logic                                   allocRequest,
  output logic                                   freeRequest,
  output logic                                   pushValid,
  output memoryPkg::responseT                    pushResponse
);

  localparam int addressBits = memoryPkg::addressBits;
  localparam int indexBits   = memoryPkg::indexBits;
  localparam int dataBits    = memoryPkg::dataBits;
  localparam int arrayCount  = memoryPkg::arrayCount;
  localparam int arrayLength = memoryPkg::arrayLength;

  logic [dataBits-1:0]    elements [arrayCount][arrayLength];
  logic [indexBits:0]     sizes [arrayCount];          // Zero to arrayLength

  logic [indexBits:0]     currentSize;
  logic [indexBits:0]     indexPlusOne;
  logic [indexBits-1:0]   topIndex;                    // Last element, for Pop
  logic [dataBits-1:0]    currentValue;
  logic [dataBits-1:0]    newValue;                    // Element write data
  logic [dataBits-1:0]    result;                      // Response data
  logic [indexBits-1:0]   elementIndex;
  logic [indexBits:0]     nextSize;
  logic [addressBits-1:0] sizeArray;                   // Alloc clears a different array
  logic                   elementWrite;
  logic                   sizeWrite;
  memoryPkg::errorT       error;

  assign currentSize  = sizes[stageRequest.array];
  assign indexPlusOne = {1'b0, stageRequest.index} + 1'b1;
  assign topIndex     = currentSize[indexBits-1:0] - 1'b1;
  assign currentValue = elements[stageRequest.array][stageRequest.index];

  // ------------------------------------------------------------------------
  // Check and compute
  // ------------------------------------------------------------------------
  always_comb begin
    error        = memoryPkg::errorNone;
    result       = '0;
    newValue     = stageRequest.data;
    elementIndex = stageRequest.index;
    elementWrite = 1'b0;
    nextSize     = currentSize;
    sizeArray    = stageRequest.array;
    sizeWrite    = 1'b0;
    allocRequest = 1'b0;
    freeRequest  = 1'b0;

    if (stageRequest.opcode == memoryPkg::opAlloc) begin
      if (allocFailed) begin
        error = memoryPkg::errorOutOfMemory;
      end else begin
        allocRequest = stageValid;
        sizeArray    = allocResult;                    // New array starts empty
        nextSize     = '0;
        sizeWrite    = 1'b1;
        result       = {{(dataBits - addressBits){1'b0}}, allocResult};
      end
    end else if (arrayState == memoryPkg::stateUnused) begin
      error = memoryPkg::errorNotAllocated;
    end else if (arrayState == memoryPkg::stateFreed) begin
      error = memoryPkg::errorFreed;
    end else begin
      case (stageRequest.opcode)
        memoryPkg::opFree: freeRequest = stageValid;
        memoryPkg::opWrite: begin
          elementWrite = 1'b1;
          if (indexPlusOne > currentSize) begin
            nextSize  = indexPlusOne;                  // Grow to cover index
            sizeWrite = 1'b1;
          end
        end
        memoryPkg::opSize: result = {{(dataBits - indexBits - 1){1'b0}}, currentSize};
        memoryPkg::opPush: begin
          if (currentSize == (indexBits + 1)'(arrayLength)) begin
            error = memoryPkg::errorFull;
          end else begin
            elementIndex = currentSize[indexBits-1:0]; // Append slot
            elementWrite = 1'b1;
            nextSize     = currentSize + 1'b1;
            sizeWrite    = 1'b1;
          end
        end
        memoryPkg::opPop: begin
          if (currentSize == '0) begin
            error = memoryPkg::errorEmpty;
          end else begin
            result    = elements[stageRequest.array][topIndex];
            nextSize  = currentSize - 1'b1;
            sizeWrite = 1'b1;
          end
        end
        default: begin                                 // Read and arithmetic
          if ({1'b0, stageRequest.index} >= currentSize) begin
            error = memoryPkg::errorOutOfBounds;
          end else begin
            case (stageRequest.opcode)
              memoryPkg::opAdd:      newValue = currentValue + stageRequest.data;
              memoryPkg::opSubtract: newValue = currentValue - stageRequest.data;
              memoryPkg::opOr:       newValue = currentValue | stageRequest.data;
              memoryPkg::opXor:      newValue = currentValue ^ stageRequest.data;
              memoryPkg::opAnd:      newValue = currentValue & stageRequest.data;
              default:               newValue = currentValue;    // Read
            endcase
            elementWrite = stageRequest.opcode != memoryPkg::opRead;
            result       = newValue;                   // New value returned
          end
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Registered update
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      pushValid <= 1'b0;
      for (int a = 0; a < arrayCount; a++) begin
        sizes[a] <= '0;
      end
    end else begin
      pushValid <= stageValid;                         // One response per request
      if (stageValid && sizeWrite) begin
        sizes[sizeArray] <= nextSize;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (stageValid) begin
      pushResponse <= '{data: result, error: error};
      if (elementWrite) begin
        elements[stageRequest.array][elementIndex] <= newValue;
      end
    end
  end

endmodule

// ==== rtl/responseQueue.sv ====
/*
  In-order response FIFO with valid/ready output.
  Depth of 2 or more, any value. The intake keeps pushes within capacity;
  a push arriving when full and not popping is dropped.
*/
`timescale 1ns/1ps

module responseQueue #(
  parameter int queueDepth = 4
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             pushValid,
  input  memoryPkg::responseT              pushResponse,
  output logic                             respValid,
  input  logic                             respReady,
  output memoryPkg::responseT              resp,
  output logic [$clog2(queueDepth+1)-1:0]  queueFill
);

  localparam int pointerBits = $clog2(queueDepth);

  memoryPkg::responseT    storage [queueDepth];
  logic [pointerBits-1:0] writePointer;
  logic [pointerBits-1:0] readPointer;
  logic                   pop;
  logic                   push;

  // Wrap for depths that are not a power of two
  function automatic logic [pointerBits-1:0] advance(input logic [pointerBits-1:0] pointer);
    return (pointer == pointerBits'(queueDepth - 1)) ? '0 : pointer + 1'b1;
  endfunction

  assign respValid = queueFill != '0;
  assign resp      = storage[readPointer];
  assign pop       = respValid && respReady;
  assign push      = pushValid && (queueFill != ($bits(queueFill))'(queueDepth) || pop);

  // ------------------------------------------------------------------------
  // Pointers and fill count
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      writePointer <= '0;
      readPointer  <= '0;
      queueFill    <= '0;
    end else begin
      if (push) begin
        writePointer <= advance(writePointer);
      end
      if (pop) begin
        readPointer <= advance(readPointer);
      end
      if (push && !pop) begin
        queueFill <= queueFill + 1'b1;
      end else if (pop && !push) begin
        queueFill <= queueFill - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      storage[writePointer] <= pushResponse;
    end
  end

endmodule

// ==== rtl/arrayMemory.sv ====
/*
  Heap of four fixed arrays of eight 16-bit elements, one request at a time.
  Responses return in request order; latency is two cycles when the queue is empty.
*/
`timescale 1ns/1ps

module arrayMemory #(
  parameter int queueDepth = 4                         // Response buffer entries, 2 or more
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 reqValid,
  output logic                 reqReady,
  input  memoryPkg::requestT   req,
  output logic                 respValid,
  input  logic                 respReady,
  output memoryPkg::responseT  resp
);

  logic                                  stageValid;
  memoryPkg::requestT                    stageRequest;
  memoryPkg::arrayStateT                 arrayState;
  logic [memoryPkg::addressBits-1:0]     allocResult;
  logic                                  allocFailed;
  logic                                  allocRequest;
  logic                                  freeRequest;
  logic                                  pushValid;
  memoryPkg::responseT                   pushResponse;
  logic [$clog2(queueDepth+1)-1:0]       queueFill;

  requestIntake #(.queueDepth(queueDepth)) intake_i (
    .clock, .reset, .reqValid, .reqReady, .req,
    .queueFill, .stageValid, .stageRequest
  );

  arrayStore store_i (
    .clock, .reset, .stageValid, .stageRequest, .arrayState,
    .allocResult, .allocFailed, .allocRequest, .freeRequest,
    .pushValid, .pushResponse
  );

  // Lookup follows the staged array number
  arrayAllocator allocator_i (
    .clock, .reset,
    .lookupArray  (stageRequest.array),
    .arrayState, .allocRequest, .freeRequest, .allocResult, .allocFailed
  );

  responseQueue #(.queueDepth(queueDepth)) queue_i (
    .clock, .reset, .pushValid, .pushResponse,
    .respValid, .respReady, .resp, .queueFill
  );

endmodule

// ==== verif/clockGen.sv ====
/*
  Clock and reset source for the testbench. 4 ns period.
  Reset is held low for 16 cycles and released on a falling edge.
*/
`timescale 1ns/1ps

module clockGen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                         // 4 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);                                  // Away from the active edge
    reset = 1'b1;
  end

endmodule

// ==== verif/arrayMemoryModel.svh ====
/*
  Reference model of the array heap, included inside the testbench module.
  Alloc clears only the size, so element values survive Free and Alloc.
*/

memoryPkg::arrayStateT              modelState [memoryPkg::arrayCount];
int                                 modelSize [memoryPkg::arrayCount];
logic [memoryPkg::dataBits-1:0]     modelData [memoryPkg::arrayCount][memoryPkg::arrayLength];
int                                 modelFreeStack [$];          // Latest free at the back
int                                 modelHighWater;              // Arrays ever handed out

function automatic void resetModel();
  for (int a = 0; a < memoryPkg::arrayCount; a++) begin
    modelState[a] = memoryPkg::stateUnused;
    modelSize[a]  = 0;
    for (int i = 0; i < memoryPkg::arrayLength; i++) begin
      modelData[a][i] = '0;
    end
  end
  modelFreeStack.delete();
  modelHighWater = 0;
endfunction

// Applies one request and returns the response the heap must give
function automatic memoryPkg::responseT predictResponse(input memoryPkg::requestT request);
  memoryPkg::responseT            response;
  logic [memoryPkg::dataBits-1:0] value;
  int                             a;
  int                             i;
  int                             size;
  a             = int'(request.array);
  i             = int'(request.index);
  size          = modelSize[a];
  response.data  = '0;
  response.error = memoryPkg::errorNone;
  if (request.opcode == memoryPkg::opAlloc) begin
    if (modelFreeStack.size() > 0) begin
      a = modelFreeStack.pop_back();                   // Reuse newest freed array
    end else if (modelHighWater < memoryPkg::arrayCount) begin
      a = modelHighWater;
      modelHighWater++;
    end else begin
      response.error = memoryPkg::errorOutOfMemory;
      return response;
    end
    modelState[a] = memoryPkg::stateLive;
    modelSize[a]  = 0;
    response.data = memoryPkg::dataBits'(a);
    return response;
  end
  if (modelState[a] != memoryPkg::stateLive) begin
    response.error = (modelState[a] == memoryPkg::stateUnused) ?
                     memoryPkg::errorNotAllocated : memoryPkg::errorFreed;
    return response;
  end
  case (request.opcode)
    memoryPkg::opFree: begin
      modelState[a] = memoryPkg::stateFreed;
      modelFreeStack.push_back(a);
    end
    memoryPkg::opWrite: begin
      modelData[a][i] = request.data;
      if (i + 1 > size) modelSize[a] = i + 1;          // Size covers highest index
    end
    memoryPkg::opSize: response.data = memoryPkg::dataBits'(size);
    memoryPkg::opPush: begin
      if (size == memoryPkg::arrayLength) begin
        response.error = memoryPkg::errorFull;
      end else begin
        modelData[a][size] = request.data;
        modelSize[a]       = size + 1;
      end
    end
    memoryPkg::opPop: begin
      if (size == 0) begin
        response.error = memoryPkg::errorEmpty;
      end else begin
        modelSize[a]  = size - 1;
        response.data = modelData[a][size-1];          // Old top
      end
    end
    default: begin                                     // Read and arithmetic
      if (i >= size) begin
        response.error = memoryPkg::errorOutOfBounds;
      end else begin
        value = modelData[a][i];
        case (request.opcode)
          memoryPkg::opAdd:      value = value + request.data;
          memoryPkg::opSubtract: value = value - request.data;
          memoryPkg::opOr:       value = value | request.data;
          memoryPkg::opXor:      value = value ^ request.data;
          memoryPkg::opAnd:      value = value & request.data;
          default:               value = value;
        endcase
        modelData[a][i] = value;
        response.data   = value;                       // New value returned
      end
    end
  endcase
  return response;
endfunction

// ==== verif/arrayMemoryTb.sv ====
/*
  Directed and random checks of the array heap against the reference model.
  Inputs change on the falling edge. Responses are checked in order as they
  transfer, and every wait loop gives up after its own timeout.
*/
`timescale 1ns/1ps

module arrayMemoryTb;

  localparam int readyTimeout = 200;                   // Cycles to wait for reqReady
  localparam int drainTimeout = 500;                   // Cycles to wait for all responses

  logic                clock;
  logic                reset;
  logic                reqValid;
  logic                reqReady;
  memoryPkg::requestT  req;
  logic                respValid;
  logic                respReady;
  memoryPkg::responseT resp;

  memoryPkg::responseT expectedQueue [$];              // Predicted, oldest first
  string               testName;
  bit                  randomReady;                    // Random respReady when set
  int                  errorCount;
  int                  checkCount;
  int                  acceptedCount;
  int                  receivedCount;
  int                  testCount;
  int                  failedTests;
  int                  testErrorStart;

  `include "arrayMemoryModel.svh"

  clockGen clockGen_i (.clock, .reset);

  arrayMemory #(.queueDepth(4)) dut_i (
    .clock, .reset, .reqValid, .reqReady, .req,
    .respValid, .respReady, .resp
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic int randomWord();
    return int'($urandom_range(0, 16'hffff));
  endfunction

  task automatic startTest(input string name);
    testName       = name;
    testErrorStart = errorCount;
  endtask

  task automatic finishTest();
    testCount++;
    if (errorCount == testErrorStart) begin
      $display("%s: ok", testName);
    end else begin
      failedTests++;
      $display("%s: failed, %0d errors", testName, errorCount - testErrorStart);
    end
  endtask

  // Returns on the falling edge before the accepting rising edge, valid still high
  task automatic sendRequest(input memoryPkg::opcodeT opcode, input int array,
                             input int index, input int data);
    memoryPkg::requestT request;
    int                 waited;
    request.opcode = opcode;
    request.array  = memoryPkg::addressBits'(array);
    request.index  = memoryPkg::indexBits'(index);
    request.data   = memoryPkg::dataBits'(data);
    @(negedge clock);
    reqValid = 1'b1;
    req      = request;
    waited   = 0;
    while (!reqReady && waited < readyTimeout) begin
      @(negedge clock);
      waited++;
    end
    if (reqReady) begin                                // Transfers on the next rising edge
      expectedQueue.push_back(predictResponse(request));
      acceptedCount++;
    end else begin
      $display("Error in %s: request not accepted within %0d cycles", testName, readyTimeout);
      errorCount++;
      reqValid = 1'b0;
    end
  endtask

  task automatic idleCycle();
    @(negedge clock);
    reqValid = 1'b0;
  endtask

  task automatic drainResponses();
    int waited;
    idleCycle();
    waited = 0;
    while (expectedQueue.size() != 0 && waited < drainTimeout) begin
      @(negedge clock);
      waited++;
    end
    if (expectedQueue.size() != 0) begin
      $display("Error in %s: %0d responses never arrived", testName, expectedQueue.size());
      errorCount++;
      expectedQueue.delete();
    end
  endtask

  task automatic checkResponse(input memoryPkg::responseT actual);
    memoryPkg::responseT expected;
    receivedCount++;
    assert (expectedQueue.size() != 0) else begin
      $display("Error in %s: a response arrived with no request outstanding", testName);
      errorCount++;
    end
    if (expectedQueue.size() != 0) begin
      expected = expectedQueue.pop_front();
      checkCount++;
      assert (actual === expected) else begin
        $display("Fail %s: expected data %h error %0d, actual data %h error %0d",
                 testName, expected.data, expected.error, actual.data, actual.error);
        errorCount++;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic resetStateTest();
    startTest("reset state");
    assert (reqReady === 1'b1 && respValid === 1'b0) else begin
      $display("Fail %s: expected reqReady 1 respValid 0, actual reqReady %b respValid %b",
               testName, reqReady, respValid);
      errorCount++;
    end
    finishTest();
  endtask

  task automatic misuseTest();
    startTest("misuse");
    sendRequest(memoryPkg::opRead, 1, 0, 0);           // Never allocated
    sendRequest(memoryPkg::opWrite, 2, 1, randomWord());
    sendRequest(memoryPkg::opPush, 3, 0, randomWord());
    sendRequest(memoryPkg::opFree, 1, 0, 0);
    sendRequest(memoryPkg::opAlloc, 0, 0, 0);          // Array 0 goes live
    sendRequest(memoryPkg::opWrite, 0, 3, randomWord());
    sendRequest(memoryPkg::opFree, 0, 0, 0);
    sendRequest(memoryPkg::opRead, 0, 3, 0);           // Freed from here on
    sendRequest(memoryPkg::opPop, 0, 0, 0);
    sendRequest(memoryPkg::opAdd, 0, 3, randomWord());
    sendRequest(memoryPkg::opFree, 0, 0, 0);           // Double free
    sendRequest(memoryPkg::opSize, 0, 0, 0);
    sendRequest(memoryPkg::opSize, 1, 0, 0);
    // Reuse array 0 to see that element 3 kept its value
    sendRequest(memoryPkg::opAlloc, 0, 0, 0);
    sendRequest(memoryPkg::opWrite, 0, 7, randomWord());   // Size 8 exposes old elements
    sendRequest(memoryPkg::opRead, 0, 3, 0);
    sendRequest(memoryPkg::opFree, 0, 0, 0);
    drainResponses();
    finishTest();
  endtask

  // A single stacked entry for array 0 keeps the order 0, 1, 2, 3
  task automatic allocationTest();
    startTest("allocation order");
    repeat (5) sendRequest(memoryPkg::opAlloc, 0, 0, 0);
    sendRequest(memoryPkg::opFree, 2, 0, 0);
    sendRequest(memoryPkg::opFree, 0, 0, 0);
    repeat (2) sendRequest(memoryPkg::opAlloc, 0, 0, 0);
    // Known value in every element, then all arrays restart empty
    for (int a = 0; a < memoryPkg::arrayCount; a++) begin
      for (int i = 0; i < memoryPkg::arrayLength; i++) begin
        sendRequest(memoryPkg::opWrite, a, i, randomWord());
      end
    end
    for (int a = 0; a < memoryPkg::arrayCount; a++) begin
      sendRequest(memoryPkg::opFree, a, 0, 0);
    end
    repeat (memoryPkg::arrayCount) sendRequest(memoryPkg::opAlloc, 0, 0, 0);
    drainResponses();
    finishTest();
  endtask

  task automatic accessTest();
    startTest("element access");
    repeat (5) sendRequest(memoryPkg::opWrite, 1, int'($urandom_range(0, 6)), randomWord());
    for (int i = 0; i < memoryPkg::arrayLength; i++) begin
      sendRequest(memoryPkg::opRead, 1, i, 0);         // Past size gives out of bounds
    end
    sendRequest(memoryPkg::opSize, 1, 0, 0);
    drainResponses();
    finishTest();
  endtask

  task automatic stackTest();
    startTest("stack use");
    repeat (memoryPkg::arrayLength + 1) sendRequest(memoryPkg::opPush, 3, 0, randomWord());
    repeat (memoryPkg::arrayLength + 1) sendRequest(memoryPkg::opPop, 3, 0, 0);
    drainResponses();
    finishTest();
  endtask

  task automatic arithmeticTest();
    memoryPkg::opcodeT opcode;
    int                index;
    startTest("arithmetic");
    for (int i = 0; i < memoryPkg::arrayLength; i++) begin
      sendRequest(memoryPkg::opWrite, 2, i, randomWord());
    end
    repeat (40) begin
      opcode = memoryPkg::opcodeT'(4'($urandom_range(7, 11)));   // Add to And
      index  = int'($urandom_range(0, 7));
      sendRequest(opcode, 2, index, randomWord());
      sendRequest(memoryPkg::opRead, 2, index, 0);
    end
    drainResponses();
    finishTest();
  endtask

  task automatic backPressureTest();
    memoryPkg::opcodeT opcode;
    startTest("back-pressure");
    randomReady = 1'b1;
    repeat (400) begin
      if ($urandom_range(0, 3) == 0) idleCycle();
      opcode = memoryPkg::opcodeT'(4'($urandom_range(0, 11)));
      sendRequest(opcode, int'($urandom_range(0, 3)), int'($urandom_range(0, 7)), randomWord());
    end
    drainResponses();
    randomReady = 1'b0;
    repeat (8) @(negedge clock);                       // Room for a stray extra response
    assert (receivedCount == acceptedCount && !respValid) else begin
      $display("Error in %s: %0d requests accepted but %0d responses received",
               testName, acceptedCount, receivedCount);
      errorCount++;
    end
    finishTest();
  endtask

  // --------------------------------------------------------------------------
  // Response side
  // --------------------------------------------------------------------------
  initial begin : collectResponses
    respReady = 1'b0;
    forever begin
      @(negedge clock);
      respReady = randomReady ? 1'($urandom_range(0, 1)) : 1'b1;
      if (respValid && respReady) begin                // Transfers on the next rising edge
        checkResponse(resp);
      end
    end
  end

  initial begin : mainSequence
    int waited;
    reqValid = 1'b0;
    req      = '0;
    void'($urandom(28));
    resetModel();
    waited = 0;
    while (reset !== 1'b1 && waited < 100) begin
      @(negedge clock);
      waited++;
    end
    if (reset !== 1'b1) begin
      $display("Error: reset was never released");
      errorCount++;
    end
    resetStateTest();
    misuseTest();                                      // Needs never-allocated arrays
    allocationTest();
    accessTest();
    stackTest();
    arithmeticTest();
    backPressureTest();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verif
rtl/memoryPkg.sv
rtl/requestIntake.sv
rtl/arrayAllocator.sv
rtl/arrayStore.sv
rtl/responseQueue.sv
rtl/arrayMemory.sv
verif/clockGen.sv
verif/arrayMemoryTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the array heap testbench with Verilator.
# Exit status is nonzero on a build error, a simulator error or a reported failure.

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module arrayMemoryTb \
  -f compile.f -o arrayMemorySim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/arrayMemorySim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "TEST FAIL" "$logFile"; then
  exit 1
fi
exit 0
